// ==== common/tpl_dac_pkg.sv ====
// Shared constants, source select codes and link beat layout, imported by the DAC transport RTL
package tpl_dac_pkg;

  // ********************************************************
  // Beat geometry
  // ********************************************************

  // Converter sample width
  localparam int SAMPLE_W = 16;

  // Samples per channel in one beat
  localparam int DATA_PATH_WIDTH = 2;

  // Octets per lane in one beat
  localparam int OCTETS_PER_BEAT = 4;

  // One lane per channel, so a channel slice and a lane are the same size
  localparam int CH_BEAT_W = SAMPLE_W * DATA_PATH_WIDTH;

  // Upper bound on converter channels
  localparam int MAX_CHANNELS = 4;

  // Full beat width at the channel bound
  localparam int LINK_BEAT_W = MAX_CHANNELS * CH_BEAT_W;

  // ********************************************************
  // Source select
  // ********************************************************

  // Per-channel sample source
  // Codes above SRC_ZERO also give zero samples
  typedef enum logic [3:0] {
    SRC_DMA     = 4'd0,
    SRC_PATTERN = 4'd1,
    SRC_PN7     = 4'd2,
    SRC_PN15    = 4'd3,
    SRC_ZERO    = 4'd4
  } src_sel_e;

  // ********************************************************
  // Link beat
  // ********************************************************

  // Same 128 bits seen as channel samples or as lane octets
  // Channel c and lane c occupy the same 32-bit slice
  typedef union packed {
    logic [MAX_CHANNELS-1:0][DATA_PATH_WIDTH-1:0][SAMPLE_W-1:0] samples;
    logic [MAX_CHANNELS-1:0][OCTETS_PER_BEAT-1:0][7:0]          octets;
  } link_beat_u;

endpackage

// ==== common/tpl_dac_cfg_if.sv ====
// Per-channel configuration bundle between the DAC core top level and one channel datapath
`timescale 1ns/1ps

interface tpl_dac_cfg_if
  import tpl_dac_pkg::*;
();

  // Sample source of this channel
  src_sel_e              data_sel;

  // Fixed pattern words, sample 0 and sample 1
  logic [SAMPLE_W-1:0]   pat_data_0;
  logic [SAMPLE_W-1:0]   pat_data_1;

  // High when the channel consumes DMA data
  logic                  enable;

  // Top level drives the configuration and reads the enable back
  modport top (
    output data_sel,
    output pat_data_0,
    output pat_data_1,
    input  enable
  );

  // Channel view
  modport chan (
    input  data_sel,
    input  pat_data_0,
    input  pat_data_1,
    output enable
  );

endinterface

// ==== source/tpl_dac_sync.sv ====
// Arm flag for the DAC datapath, set by a software sync request and released by external sync
`timescale 1ns/1ps

module tpl_dac_sync #(
  parameter bit EXT_SYNC = 1'b0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic dac_sync,
  input  logic dac_sync_in,
  output logic arm
);

  // Software request history
  logic sync_req_d1;
  logic sync_req_d2;

  // External sync, two-flop synchronizer plus one stage for edge detect
  logic sync_in_meta;
  logic sync_in_sync;
  logic sync_in_last;

  logic sync_req_edge;
  logic sync_in_edge;

  // ********************************************************
  // Input registers
  // ********************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_req_d1  <= 1'b0;
      sync_req_d2  <= 1'b0;
      sync_in_meta <= 1'b0;
      sync_in_sync <= 1'b0;
      sync_in_last <= 1'b0;
    end else begin
      sync_req_d1  <= dac_sync;
      sync_req_d2  <= sync_req_d1;
      sync_in_meta <= dac_sync_in;
      sync_in_sync <= sync_in_meta;
      sync_in_last <= sync_in_sync;
    end
  end

  // Rising edges
  assign sync_req_edge = sync_req_d1 & ~sync_req_d2;
  assign sync_in_edge  = sync_in_sync & ~sync_in_last;

  // ********************************************************
  // Arm flag
  // ********************************************************

  // Software request wins over external release
  // Without external sync the flag lasts a single cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arm <= 1'b0;
    end else if (sync_req_edge) begin
      arm <= ~arm;
    end else if (sync_in_edge) begin
      arm <= 1'b0;
    end else if (!EXT_SYNC) begin
      arm <= 1'b0;
    end
  end

endmodule

// ==== source/tpl_dac_pn.sv ====
// PN7 and PN15 test sequence generators, one 32-bit beat per advance, reseeded while armed
`timescale 1ns/1ps

module tpl_dac_pn
  import tpl_dac_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 arm,
  input  logic                 advance,
  output logic [CH_BEAT_W-1:0] pn7_data,
  output logic [CH_BEAT_W-1:0] pn15_data
);

  // LFSR lengths, taps at len-1 and len-2
  localparam int PN7_LEN  = 7;
  localparam int PN15_LEN = 15;

  // All-ones seeds held in the shared 15-bit state
  localparam logic [14:0] PN7_SEED  = 15'h007f;
  localparam logic [14:0] PN15_SEED = 15'h7fff;

  logic [14:0] pn7_state;
  logic [14:0] pn15_state;

  // Next state in the upper 15 bits, produced beat in the lower 32
  logic [46:0] pn7_run;
  logic [46:0] pn15_run;

  // ********************************************************
  // Fibonacci LFSR, 32 shifts per call
  // ********************************************************

  // Output bit is the top state bit
  // First bit produced lands in bit 31
  function automatic logic [46:0] lfsr_run(input logic [14:0] seed, input int len);
    logic [14:0] s;
    logic [14:0] mask;
    logic [31:0] bits;
    logic        fb;
    s    = seed;
    mask = 15'((1 << len) - 1);
    for (int i = 31; i >= 0; i--) begin
      bits[i] = s[len-1];
      fb      = s[len-1] ^ s[len-2];
      s       = ((s << 1) | {14'd0, fb}) & mask;
    end
    return {s, bits};
  endfunction

  assign pn7_run  = lfsr_run(pn7_state, PN7_LEN);
  assign pn15_run = lfsr_run(pn15_state, PN15_LEN);

  // Beat that the next advance consumes
  assign pn7_data  = pn7_run[CH_BEAT_W-1:0];
  assign pn15_data = pn15_run[CH_BEAT_W-1:0];

  // Arm restarts both sequences from the seed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pn7_state  <= PN7_SEED;
      pn15_state <= PN15_SEED;
    end else if (arm) begin
      pn7_state  <= PN7_SEED;
      pn15_state <= PN15_SEED;
    end else if (advance) begin
      pn7_state  <= pn7_run[46:32];
      pn15_state <= pn15_run[46:32];
    end
  end

endmodule

// ==== channel/tpl_dac_channel.sv ====
// One converter channel, picks the beat from DMA, pattern, PN7, PN15 or zero
`timescale 1ns/1ps

module tpl_dac_channel
  import tpl_dac_pkg::*;
(
  tpl_dac_cfg_if.chan          cfg,
  input  logic [CH_BEAT_W-1:0] dma_data,
  input  logic [CH_BEAT_W-1:0] pn7_data,
  input  logic [CH_BEAT_W-1:0] pn15_data,
  output logic [CH_BEAT_W-1:0] dac_data
);

  // ********************************************************
  // Source words in beat order
  // ********************************************************

  // Sample 0 sits in the low half of a channel beat
  logic [CH_BEAT_W-1:0] pat_beat;
  logic [CH_BEAT_W-1:0] pn7_beat;
  logic [CH_BEAT_W-1:0] pn15_beat;

  // Pattern words
  assign pat_beat = {cfg.pat_data_1, cfg.pat_data_0};

  // PN words carry sample 0 in the high half
  // Halves swap so the oldest PN bits become sample 0
  assign pn7_beat  = {pn7_data[SAMPLE_W-1:0], pn7_data[CH_BEAT_W-1:SAMPLE_W]};
  assign pn15_beat = {pn15_data[SAMPLE_W-1:0], pn15_data[CH_BEAT_W-1:SAMPLE_W]};

  // ********************************************************
  // Source multiplexer
  // ********************************************************

  always_comb begin
    case (cfg.data_sel)
      SRC_DMA: begin
        dac_data = dma_data;
      end
      SRC_PATTERN: begin
        dac_data = pat_beat;
      end
      SRC_PN7: begin
        dac_data = pn7_beat;
      end
      SRC_PN15: begin
        dac_data = pn15_beat;
      end
      // SRC_ZERO and every unused code
      default: begin
        dac_data = '0;
      end
    endcase
  end

  // DMA side only feeds channels that take its data
  assign cfg.enable = (cfg.data_sel == SRC_DMA);

endmodule

// ==== source/tpl_dac_framer.sv ====
// Maps channel samples to lane octets and holds the link beat under valid/ready flow control
`timescale 1ns/1ps

module tpl_dac_framer
  import tpl_dac_pkg::*;
#(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [NUM_CHANNELS*CH_BEAT_W-1:0] dac_data,
  input  logic                              arm,
  output logic                              load,
  output logic                              link_valid,
  input  logic                              link_ready,
  output logic [NUM_CHANNELS*CH_BEAT_W-1:0] link_data
);

  // Beat seen as samples on the way in and octets on the way out
  link_beat_u beat;

  // Lanes in link order, octet 0 in the lowest byte
  logic [NUM_CHANNELS*CH_BEAT_W-1:0] lanes;

  // ********************************************************
  // Sample to octet mapping
  // ********************************************************

  // Unused channels stay zero
  always_comb begin
    beat = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int k = 0; k < DATA_PATH_WIDTH; k++) begin
        beat.samples[c][k] = dac_data[c*CH_BEAT_W + k*SAMPLE_W +: SAMPLE_W];
      end
    end
  end

  // High byte of sample k goes first as octet 2k
  // Low byte follows as octet 2k+1
  always_comb begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int k = 0; k < DATA_PATH_WIDTH; k++) begin
        lanes[c*CH_BEAT_W + (2*k)*8 +: 8]   = beat.octets[c][2*k+1];
        lanes[c*CH_BEAT_W + (2*k+1)*8 +: 8] = beat.octets[c][2*k];
      end
    end
  end

  // ********************************************************
  // Link output register
  // ********************************************************

  // Room in the register and datapath not held by sync
  assign load = (!link_valid || link_ready) && !arm;

  // Without a load, a ready beat leaves and the register empties
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link_valid <= 1'b0;
    end else if (load) begin
      link_valid <= 1'b1;
    end else if (link_ready) begin
      link_valid <= 1'b0;
    end
  end

  // Beat payload, steady while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      link_data <= lanes;
    end
  end

endmodule

// ==== source/tpl_dac_core.sv ====
// Top level of the JESD204 DAC transport layer, DMA samples in and link beats out
`timescale 1ns/1ps

module tpl_dac_core
  import tpl_dac_pkg::*;
#(
  parameter int NUM_CHANNELS = 2,
  parameter bit EXT_SYNC     = 1'b0
) (
  input  logic                                      clk,
  input  logic                                      rst_n,

  // DMA side
  output logic                                      dma_rd,
  input  logic [NUM_CHANNELS*CH_BEAT_W-1:0]         dma_data,

  // Link side
  output logic                                      link_valid,
  input  logic                                      link_ready,
  output logic [NUM_CHANNELS*CH_BEAT_W-1:0]         link_data,

  // Sync control and status
  input  logic                                      dac_sync,
  input  logic                                      dac_sync_in,
  output logic                                      sync_in_status,

  // Channel configuration
  input  logic [NUM_CHANNELS*$bits(src_sel_e)-1:0]  data_sel,
  input  logic [NUM_CHANNELS*SAMPLE_W-1:0]          pat_data_0,
  input  logic [NUM_CHANNELS*SAMPLE_W-1:0]          pat_data_1,
  output logic [NUM_CHANNELS-1:0]                   enable
);

  localparam int SEL_W = $bits(src_sel_e);

  logic                              arm;
  logic                              load;
  logic [CH_BEAT_W-1:0]              pn7_data;
  logic [CH_BEAT_W-1:0]              pn15_data;
  logic [NUM_CHANNELS*CH_BEAT_W-1:0] dac_data;

  // ********************************************************
  // Sync and test sequences
  // ********************************************************

  tpl_dac_sync #(
    .EXT_SYNC (EXT_SYNC)
  ) i_sync (
    .clk         (clk),
    .rst_n       (rst_n),
    .dac_sync    (dac_sync),
    .dac_sync_in (dac_sync_in),
    .arm         (arm)
  );

  assign sync_in_status = arm;

  // PN advances with every beat load
  tpl_dac_pn i_pn (
    .clk       (clk),
    .rst_n     (rst_n),
    .arm       (arm),
    .advance   (load),
    .pn7_data  (pn7_data),
    .pn15_data (pn15_data)
  );

  // ********************************************************
  // Channels
  // ********************************************************

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
    tpl_dac_cfg_if cfg_if ();

    assign cfg_if.data_sel   = src_sel_e'(data_sel[i*SEL_W +: SEL_W]);
    assign cfg_if.pat_data_0 = pat_data_0[i*SAMPLE_W +: SAMPLE_W];
    assign cfg_if.pat_data_1 = pat_data_1[i*SAMPLE_W +: SAMPLE_W];
    assign enable[i]         = cfg_if.enable;

    tpl_dac_channel i_channel (
      .cfg       (cfg_if.chan),
      .dma_data  (dma_data[i*CH_BEAT_W +: CH_BEAT_W]),
      .pn7_data  (pn7_data),
      .pn15_data (pn15_data),
      .dac_data  (dac_data[i*CH_BEAT_W +: CH_BEAT_W])
    );
  end

  // ********************************************************
  // Framer and link
  // ********************************************************

  tpl_dac_framer #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) i_framer (
    .clk        (clk),
    .rst_n      (rst_n),
    .dac_data   (dac_data),
    .arm        (arm),
    .load       (load),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_data  (link_data)
  );

  // DMA word is consumed on every load
  assign dma_rd = load;

endmodule

// ==== dv/tpl_dac_tb.sv ====
// Testbench for the DAC transport core with random DMA and link stimulus checked against a model
`timescale 1ns/1ps

module tpl_dac_tb
  import tpl_dac_pkg::*;
();

  localparam int NUM_CH         = 2;
  localparam int BEAT_W         = NUM_CH * CH_BEAT_W;
  localparam int SEL_W          = 4;
  localparam int RESET_CYCLES   = 3;
  localparam int DMA_CYCLES     = 400;
  localparam int PAT_CYCLES     = 150;
  localparam int PN_CYCLES      = 200;
  localparam int ARM_CYCLES     = 20;
  localparam int RELEASE_CYCLES = 20;
  localparam int RESUME_CYCLES  = 100;
  localparam int ZERO_CYCLES    = 200;
  // Sum of all phases plus the single cycles spent on setting up each one
  localparam int TOTAL_CYCLES   = RESET_CYCLES + DMA_CYCLES + 2 * PAT_CYCLES + PN_CYCLES
                                + ARM_CYCLES + RELEASE_CYCLES + RESUME_CYCLES + ZERO_CYCLES + 60;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_CYCLES;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       dma_rd;
  logic [BEAT_W-1:0]          dma_data;
  logic                       link_valid;
  logic                       link_ready;
  logic [BEAT_W-1:0]          link_data;
  logic                       dac_sync;
  logic                       dac_sync_in;
  logic                       sync_in_status;
  logic [NUM_CH*SEL_W-1:0]    data_sel;
  logic [NUM_CH*SAMPLE_W-1:0] pat_data_0;
  logic [NUM_CH*SAMPLE_W-1:0] pat_data_1;
  logic [NUM_CH-1:0]          enable;

  // Model state
  logic [BEAT_W-1:0] exp_q[$];
  logic [BEAT_W-1:0] held_data;
  logic [BEAT_W-1:0] head;
  logic [46:0]       seq7;
  logic [46:0]       seq15;
  logic [14:0]       pn7_hist;
  logic [14:0]       pn15_hist;
  logic [1:0]        sync_hist;
  logic [2:0]        sync_in_hist;
  logic              exp_valid;
  logic              exp_arm;
  logic              exp_load;
  logic              stalled;
  int                error_count    = 0;
  int                check_count    = 0;
  int                transfer_count = 0;
  int                cycle_count    = 0;

  always #5 clk = ~clk;

  tpl_dac_core #(
    .NUM_CHANNELS (NUM_CH),
    .EXT_SYNC     (1'b1)
  ) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .dma_rd         (dma_rd),
    .dma_data       (dma_data),
    .link_valid     (link_valid),
    .link_ready     (link_ready),
    .link_data      (link_data),
    .dac_sync       (dac_sync),
    .dac_sync_in    (dac_sync_in),
    .sync_in_status (sync_in_status),
    .data_sel       (data_sel),
    .pat_data_0     (pat_data_0),
    .pat_data_1     (pat_data_1),
    .enable         (enable)
  );

  // ************************************************************
  // Checks and reference functions
  // ************************************************************

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Bit stream of x^len + x^(len-1) + 1 where seq[n] is the n-th bit and seq[0] the oldest
  function automatic logic [46:0] pn_sequence(input logic [14:0] hist, input int len);
    logic [46:0] seq;
    seq = '0;
    for (int n = 0; n < len; n++) begin
      seq[n] = hist[n];
    end
    for (int n = len; n < len + 32; n++) begin
      seq[n] = seq[n-len] ^ seq[n-len+1];
    end
    return seq;
  endfunction

  // First produced bit lands in bit 31
  function automatic logic [31:0] pn_word(input logic [46:0] seq);
    logic [31:0] w;
    for (int n = 0; n < 32; n++) begin
      w[31-n] = seq[n];
    end
    return w;
  endfunction

  // Last len bits become the history for the next beat
  function automatic logic [14:0] pn_history(input logic [46:0] seq, input int len);
    logic [14:0] h;
    h = '0;
    for (int n = 0; n < len; n++) begin
      h[n] = seq[32+n];
    end
    return h;
  endfunction

  function automatic logic [NUM_CH-1:0] expected_enable(input logic [NUM_CH*SEL_W-1:0] sel);
    logic [NUM_CH-1:0] en;
    for (int c = 0; c < NUM_CH; c++) begin
      en[c] = (sel[c*SEL_W +: SEL_W] == SRC_DMA);
    end
    return en;
  endfunction

  function automatic logic [BEAT_W-1:0] expected_beat(
    input logic [BEAT_W-1:0]          dma,
    input logic [NUM_CH*SEL_W-1:0]    sel,
    input logic [NUM_CH*SAMPLE_W-1:0] p0,
    input logic [NUM_CH*SAMPLE_W-1:0] p1,
    input logic [31:0]                w7,
    input logic [31:0]                w15
  );
    logic [15:0]       s0;
    logic [15:0]       s1;
    logic [BEAT_W-1:0] beat;
    beat = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      case (sel[c*SEL_W +: SEL_W])
        SRC_DMA: begin
          s0 = dma[c*32 +: 16];
          s1 = dma[c*32+16 +: 16];
        end
        SRC_PATTERN: begin
          s0 = p0[c*16 +: 16];
          s1 = p1[c*16 +: 16];
        end
        // PN sample 0 is the older half of the word
        SRC_PN7: begin
          s0 = w7[31:16];
          s1 = w7[15:0];
        end
        SRC_PN15: begin
          s0 = w15[31:16];
          s1 = w15[15:0];
        end
        default: begin
          s0 = '0;
          s1 = '0;
        end
      endcase
      // Octet 0 sits in the lowest byte of the lane with the high byte of each sample first
      beat[c*32 +: 8]    = s0[15:8];
      beat[c*32+8 +: 8]  = s0[7:0];
      beat[c*32+16 +: 8] = s1[15:8];
      beat[c*32+24 +: 8] = s1[7:0];
    end
    return beat;
  endfunction

  // ************************************************************
  // Reference model and monitor
  // ************************************************************

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      exp_valid    = 1'b0;
      exp_arm      = 1'b0;
      stalled      = 1'b0;
      sync_hist    = '0;
      sync_in_hist = '0;
      pn7_hist     = 15'h7fff;
      pn15_hist    = 15'h7fff;
    end else begin
      // Room in the output register and not armed
      exp_load = (!exp_valid || link_ready) && !exp_arm;
      check_value("link_valid", link_valid, exp_valid);
      check_value("sync_in_status", sync_in_status, exp_arm);
      check_value("dma_rd", dma_rd, exp_load);
      check_value("enable", enable, expected_enable(data_sel));
      // Stalled beat must not move
      if (stalled) begin
        check_value("link_data", link_data, held_data);
      end
      stalled   = link_valid && !link_ready;
      held_data = link_data;
      if (link_valid && link_ready) begin
        transfer_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Link transfer at %0t without any beat read from DMA", $time);
        end else begin
          head = exp_q.pop_front();
          check_value("link_data", link_data, head);
        end
      end
      // Beat is built from this cycle's inputs and PN moves on with it
      if (dma_rd) begin
        seq7  = pn_sequence(pn7_hist, 7);
        seq15 = pn_sequence(pn15_hist, 15);
        exp_q.push_back(expected_beat(dma_data, data_sel, pat_data_0, pat_data_1,
                                      pn_word(seq7), pn_word(seq15)));
        pn7_hist  = pn_history(seq7, 7);
        pn15_hist = pn_history(seq15, 15);
      end
      exp_valid = exp_load || (exp_valid && !link_ready);
      if (exp_arm) begin
        pn7_hist  = 15'h7fff;
        pn15_hist = 15'h7fff;
      end
      // Request rise toggles two edges later and sync input rise clears three edges later
      if (sync_hist[0] && !sync_hist[1]) begin
        exp_arm = !exp_arm;
      end else if (sync_in_hist[1] && !sync_in_hist[2]) begin
        exp_arm = 1'b0;
      end
      sync_hist    = {sync_hist[0], dac_sync};
      sync_in_hist = {sync_in_hist[1:0], dac_sync_in};
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("test failed");
      $finish;
    end
  end

  // ************************************************************
  // Stimulus
  // ************************************************************

  // Random back-pressure and a new DMA word after every read
  task automatic drive_link_side();
    forever begin
      @(posedge clk);
      link_ready <= (($urandom % 100) < 70);
      if (dma_rd) begin
        dma_data <= {$urandom, $urandom};
      end
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic set_sources(input logic [3:0] sel1, input logic [3:0] sel0);
    @(posedge clk);
    data_sel <= {sel1, sel0};
  endtask

  task automatic run_sync_sequence();
    int transfers_before;
    @(posedge clk);
    dac_sync <= 1'b1;
    // Request edge is registered once and toggles arm on the next edge
    run_cycles(2);
    @(negedge clk);
    check_value("sync_in_status", sync_in_status, 1'b1);
    // Held beat drains while nothing new loads
    while (link_valid) begin
      @(negedge clk);
    end
    run_cycles(ARM_CYCLES);
    dac_sync <= 1'b0;
    @(negedge clk);
    // Still armed and the link stays idle
    check_value("sync_in_status", sync_in_status, 1'b1);
    check_value("link_valid", link_valid, 1'b0);
    @(posedge clk);
    dac_sync_in <= 1'b1;
    run_cycles(3);
    @(negedge clk);
    check_value("sync_in_status", sync_in_status, 1'b0);
    transfers_before = transfer_count;
    run_cycles(RELEASE_CYCLES);
    dac_sync_in <= 1'b0;
    @(negedge clk);
    if (transfer_count == transfers_before) begin
      error_count++;
      $display("No link transfers resumed after the external sync release");
    end
  endtask

  initial begin
    void'($urandom(32'hc0d0));
    rst_n       = 1'b0;
    link_ready  = 1'b0;
    dma_data    = {$urandom, $urandom};
    dac_sync    = 1'b0;
    dac_sync_in = 1'b0;
    data_sel    = {SEL_W'(SRC_ZERO), SEL_W'(SRC_ZERO)};
    pat_data_0  = '0;
    pat_data_1  = '0;

    // Outputs stay quiet in reset
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_value("link_valid", link_valid, 1'b0);
      check_value("sync_in_status", sync_in_status, 1'b0);
      check_value("enable", enable, '0);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    fork
      drive_link_side();
    join_none

    // DMA passthrough under back-pressure
    set_sources(SRC_DMA, SRC_DMA);
    run_cycles(DMA_CYCLES);

    // Pattern on one channel, DMA on the other
    @(posedge clk);
    pat_data_0 <= $urandom;
    pat_data_1 <= $urandom;
    set_sources(SRC_PATTERN, SRC_DMA);
    run_cycles(PAT_CYCLES);
    set_sources(SRC_DMA, SRC_PATTERN);
    run_cycles(PAT_CYCLES);

    // PN sequences, then restart through sync
    set_sources(SRC_PN15, SRC_PN7);
    run_cycles(PN_CYCLES);
    run_sync_sequence();
    run_cycles(RESUME_CYCLES);

    // Zero code, an unused code, then random codes over all sources
    set_sources(4'd9, SRC_ZERO);
    run_cycles(19);
    for (int i = 0; i < (ZERO_CYCLES - 20) / 10; i++) begin
      set_sources(4'($urandom), 4'($urandom));
      run_cycles(9);
    end

    // At most the beat held in the output register is still in flight
    @(negedge clk);
    if (exp_q.size() > 1) begin
      error_count++;
      $display("%0d beats read from DMA never reached the link", exp_q.size() - 1);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tpl_dac.f ====
common/tpl_dac_pkg.sv
common/tpl_dac_cfg_if.sv
source/tpl_dac_sync.sv
source/tpl_dac_pn.sv
channel/tpl_dac_channel.sv
source/tpl_dac_framer.sv
source/tpl_dac_core.sv
dv/tpl_dac_tb.sv

// ==== Bender.yml ====
package:
  name: tpl_dac

# Package first, then interface, then modules bottom up
sources:
  - files:
      - common/tpl_dac_pkg.sv
      - common/tpl_dac_cfg_if.sv
      - source/tpl_dac_sync.sv
      - source/tpl_dac_pn.sv
      - channel/tpl_dac_channel.sv
      - source/tpl_dac_framer.sv
      - source/tpl_dac_core.sv

  - target: simulation
    files:
      - dv/tpl_dac_tb.sv
